// ==== include/t07_consts.svh ====
`ifndef T07_CONSTS_SVH
`define T07_CONSTS_SVH

// display size in pixels
`define T07_SCREEN_W 320
`define T07_SCREEN_H 240

// play button bounding box
`define T07_SPRITE_W 61
`define T07_SPRITE_H 70

// register values after reset
`define T07_DEF_ORIGIN_X 9'd125
`define T07_DEF_ORIGIN_Y 8'd90
`define T07_DEF_FG       12'hFFF
`define T07_DEF_BG       12'h000

// register byte offsets
`define T07_REG_CTRL   4'h0
`define T07_REG_ORIGIN 4'h4
`define T07_REG_COLOR  4'h8

`define T07_RESP_OKAY   2'b00
`define T07_RESP_SLVERR 2'b10

`endif

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module t07_menuScreen_tb -f sources.f -o simv \
  && ./obj_dir/simv > sim.log 2>&1 || echo "build or simulation stopped with an error"
[ -f sim.log ] && cat sim.log || { echo "no simulation log"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0

// ==== sources.f ====
+incdir+include
verilog/t07_pkg.sv
verilog/t07_menuRegs.sv
verilog/t07_pixelScan.sv
verilog/t07_generatePlayButton.sv
verilog/t07_pixelColor.sv
verilog/t07_menuScreen.sv
testbench/t07_clkGen.sv
testbench/t07_menuScreen_tb.sv

// ==== testbench/t07_clkGen.sv ====
`timescale 1ns/1ps

module t07_clkGen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk; // 4 ns period
    end
  end

endmodule

// ==== testbench/t07_menuScreen_tb.sv ====
`timescale 1ns/1ps
`include "t07_consts.svh"

module t07_menuScreen_tb;

  localparam int screenW = `T07_SCREEN_W;
  localparam int frameSize = `T07_SCREEN_W * `T07_SCREEN_H;
  localparam int axiTimeout = 50;
  localparam int pixelTimeout = 200; // cycles allowed for one pixel including stalls

  logic clk;
  logic nrst;
  logic [3:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [3:0] araddr;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  t07_pkg::pixel_t pixel;
  logic pixelValid;
  logic pixelReady;

  integer seed = 32'h2809_db3e;
  logic randomStall;
  int stalledCycles;
  t07_pkg::rgb_t frameRgb [frameSize]; // colors of the last captured frame

  t07_clkGen u_t07_clkGen (.clk(clk));

  t07_menuScreen u_t07_menuScreen (
    .clk(clk), .nrst(nrst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .pixel(pixel), .pixelValid(pixelValid), .pixelReady(pixelReady)
  );

  task automatic stopWithFailure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic comparePixel(string what, t07_pkg::rgb_t got, t07_pkg::rgb_t exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s color %h, expected %h", $time, what, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic compareWord(string what, t07_pkg::regWord_u got, t07_pkg::regWord_u exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s read %h, expected %h", $time, what, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic compareResp(string what, logic [1:0] got, logic [1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s response %b, expected %b", $time, what, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic compareFlag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic axiWrite(input logic [3:0] addr, input t07_pkg::regWord_u data,
                          output logic [1:0] resp);
    int waited;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    #1; // look just before the rising edge
    while (!(awready && wready)) begin
      if (waited == axiTimeout) begin
        $display("timeout: write address and data were never accepted");
        stopWithFailure();
      end
      waited++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    waited  = 0;
    #1;
    while (!bvalid) begin
      if (waited == axiTimeout) begin
        $display("timeout: no write response arrived");
        stopWithFailure();
      end
      waited++;
      @(negedge clk);
      #1;
    end
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axiRead(input logic [3:0] addr, output t07_pkg::regWord_u data,
                         output logic [1:0] resp);
    int waited;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    waited  = 0;
    #1;
    while (!arready) begin
      if (waited == axiTimeout) begin
        $display("timeout: read address was never accepted");
        stopWithFailure();
      end
      waited++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    rready  = 1'b1;
    waited  = 0;
    #1;
    while (!rvalid) begin
      if (waited == axiTimeout) begin
        $display("timeout: no read data arrived");
        stopWithFailure();
      end
      waited++;
      @(negedge clk);
      #1;
    end
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // returns the pixel that the coming rising edge transfers
  task automatic nextPixel(output t07_pkg::pixel_t px);
    logic [31:0] rnd;
    for (int waited = 0; waited < pixelTimeout; waited++) begin
      @(negedge clk);
      rnd = $random(seed);
      pixelReady = randomStall ? rnd[0] : 1'b1;
      if (pixelValid && !pixelReady) stalledCycles++;
      if (pixelValid && pixelReady) begin
        px = pixel;
        return;
      end
    end
    $display("timeout: no pixel was accepted within %0d cycles", pixelTimeout);
    stopWithFailure();
  endtask

  task automatic collectFrame();
    t07_pkg::pixel_t px;
    int skipped;
    skipped = 0;
    nextPixel(px);
    while (!px.frameStart) begin
      if (skipped > frameSize) begin
        $display("timeout: no frame start seen in a whole frame of pixels");
        stopWithFailure();
      end
      skipped++;
      nextPixel(px);
    end
    for (int n = 0; n < frameSize; n++) begin
      if (n > 0) nextPixel(px);
      compareFlag($sformatf("frameStart at pixel %0d", n), px.frameStart, logic'(n == 0));
      compareFlag($sformatf("lineEnd at pixel %0d", n), px.lineEnd,
                  logic'((n % screenW) == screenW - 1));
      frameRgb[n] = px.rgb;
    end
    nextPixel(px); // first pixel of the following frame
    compareFlag("frameStart after a full frame", px.frameStart, 1'b1);
  endtask

  task automatic checkPixelAt(int x, int y, t07_pkg::rgb_t exp);
    comparePixel($sformatf("pixel %0d,%0d", x, y), frameRgb[y * screenW + x], exp);
  endtask

  // origin 0,0 with fg 0F0 and bg 00F
  task automatic checkMovedFrame();
    checkPixelAt(30, 40, 12'h0F0);
    checkPixelAt(0, 40, 12'h00F);
    checkPixelAt(`T07_DEF_ORIGIN_X + 30, `T07_DEF_ORIGIN_Y + 40, 12'h00F);
  endtask

  // valid outputs stay low while nrst is asserted
  task automatic checkResetState();
    compareFlag("pixelValid during reset", pixelValid, 1'b0);
    compareFlag("bvalid during reset", bvalid, 1'b0);
    compareFlag("rvalid during reset", rvalid, 1'b0);
  endtask

  // scan starts at 0,0 which lies outside the default sprite box
  task automatic checkFirstPixel();
    t07_pkg::pixel_t px;
    nextPixel(px);
    compareFlag("frameStart of the first pixel", px.frameStart, 1'b1);
    compareFlag("lineEnd of the first pixel", px.lineEnd, 1'b0);
    comparePixel("first pixel", px.rgb, `T07_DEF_BG);
  endtask

  task automatic testResetValues();
    t07_pkg::regWord_u word;
    t07_pkg::regWord_u exp;
    logic [1:0] resp;
    axiRead(`T07_REG_ORIGIN, word, resp);
    exp = '0;
    exp.originView.x = `T07_DEF_ORIGIN_X;
    exp.originView.y = `T07_DEF_ORIGIN_Y;
    compareWord("ORIGIN after reset", word, exp);
    compareResp("ORIGIN read", resp, `T07_RESP_OKAY);
    axiRead(`T07_REG_COLOR, word, resp);
    exp = '0;
    exp.colorView.fg = `T07_DEF_FG;
    exp.colorView.bg = `T07_DEF_BG;
    compareWord("COLOR after reset", word, exp);
    compareResp("COLOR read", resp, `T07_RESP_OKAY);
    word = 32'hA5A5_5A5A;
    axiWrite(4'hC, word, resp); // nothing mapped at 0xC
    compareResp("unmapped write", resp, `T07_RESP_SLVERR);
    axiRead(4'hC, word, resp);
    compareWord("unmapped read", word, '0);
    compareResp("unmapped read", resp, `T07_RESP_SLVERR);
  endtask

  task automatic testDefaultFrame();
    collectFrame();
    checkPixelAt(`T07_DEF_ORIGIN_X + 30, `T07_DEF_ORIGIN_Y + 40, `T07_DEF_FG);
    checkPixelAt(`T07_DEF_ORIGIN_X, `T07_DEF_ORIGIN_Y + 36, `T07_DEF_BG);
    checkPixelAt(10, 10, `T07_DEF_BG);
  endtask

  task automatic testMovedOrigin();
    t07_pkg::regWord_u word;
    logic [1:0] resp;
    word = '0; // origin 0,0
    axiWrite(`T07_REG_ORIGIN, word, resp);
    compareResp("ORIGIN write", resp, `T07_RESP_OKAY);
    word = '0;
    word.colorView.fg = 12'h0F0;
    word.colorView.bg = 12'h00F;
    axiWrite(`T07_REG_COLOR, word, resp);
    compareResp("COLOR write", resp, `T07_RESP_OKAY);
    collectFrame();
    checkMovedFrame();
  endtask

  task automatic testEnableOff();
    logic [1:0] resp;
    axiWrite(`T07_REG_CTRL, '0, resp);
    compareResp("CTRL write", resp, `T07_RESP_OKAY);
    collectFrame();
    for (int n = 0; n < frameSize; n++) begin
      checkPixelAt(n % screenW, n / screenW, 12'h00F);
    end
  endtask

  task automatic testBackPressure();
    logic [1:0] resp;
    axiWrite(`T07_REG_CTRL, 32'h1, resp);
    compareResp("CTRL write", resp, `T07_RESP_OKAY);
    stalledCycles = 0;
    randomStall = 1'b1;
    collectFrame(); // exactly one frame of pixels between the markers
    randomStall = 1'b0;
    if (stalledCycles == 0) begin
      $display("the output was never stalled during the back-pressure frame");
      stopWithFailure();
    end
    checkMovedFrame();
  endtask

  initial begin
    nrst = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    pixelReady = 1'b1;
    randomStall = 1'b0;
    stalledCycles = 0;
    repeat (10) @(negedge clk);
    checkResetState();
    nrst = 1'b1;
    checkFirstPixel();
    testResetValues();
    testDefaultFrame();
    testMovedOrigin();
    testEnableOff();
    testBackPressure();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== verilog/t07_generatePlayButton.sv ====
`timescale 1ns/1ps
`include "t07_consts.svh"

module t07_generatePlayButton (
  input  logic                clk,
  input  logic                nrst,
  input  logic                advance,
  input  t07_pkg::scanPos_t   pos,
  input  logic                posValid,
  input  t07_pkg::screenPos_t origin,
  output t07_pkg::scanPos_t   hitPos,
  output logic                hit,
  output logic                hitValid
);

  logic [9:0] dx; // bit 9 set when left of the origin
  logic [8:0] dy; // bit 8 set when above the origin
  logic       inBox;

  function automatic logic span(input logic [5:0] col, input logic [5:0] lo,
                                input logic [5:0] hi);
    return (col >= lo) && (col <= hi);
  endfunction

  // bitmap as column runs per row, offsets from the top left corner
  function automatic logic bitmapHit(input logic [6:0] row, input logic [5:0] col);
    logic m;
    m = 1'b0;
    case (row) inside
      // "play" text
      7'd0: m = span(col, 9, 12) || span(col, 53, 53);
      7'd1: m = span(col, 8, 13) || span(col, 53, 53);
      7'd2: m = span(col, 7, 9) || span(col, 12, 14) || span(col, 53, 54);
      7'd3: m = span(col, 6, 8) || span(col, 13, 15) || span(col, 53, 54);
      7'd4: m = span(col, 6, 7) || span(col, 14, 15) || span(col, 53, 54);
      [7'd5:7'd6]: m = span(col, 6, 7) || span(col, 15, 15) || span(col, 53, 54);
      [7'd7:7'd9]: m = span(col, 6, 7) || span(col, 53, 54);
      7'd10: m = span(col, 6, 7) || span(col, 9, 12) || span(col, 53, 54);
      7'd11: m = span(col, 6, 13) || span(col, 21, 22) || span(col, 24, 28)
              || span(col, 36, 38) || span(col, 48, 54);
      7'd12: m = span(col, 6, 9) || span(col, 12, 14) || span(col, 22, 29)
              || span(col, 37, 39) || span(col, 47, 54);
      7'd13: m = span(col, 6, 8) || span(col, 13, 15) || span(col, 22, 25)
              || span(col, 28, 30) || span(col, 38, 39) || span(col, 46, 48)
              || span(col, 52, 54);
      7'd14: m = span(col, 6, 7) || span(col, 14, 15) || span(col, 22, 23)
              || span(col, 29, 30) || span(col, 38, 39) || span(col, 45, 47)
              || span(col, 53, 54);
      7'd15: m = span(col, 6, 7) || span(col, 14, 15) || span(col, 22, 23)
              || span(col, 28, 30) || span(col, 38, 39) || span(col, 45, 46)
              || span(col, 53, 54);
      7'd16: m = span(col, 6, 7) || span(col, 14, 15) || span(col, 22, 24)
              || span(col, 27, 29) || span(col, 38, 39) || span(col, 45, 46)
              || span(col, 53, 54);
      7'd17: m = span(col, 6, 7) || span(col, 14, 15) || span(col, 22, 28)
              || span(col, 38, 39) || span(col, 45, 46) || span(col, 53, 54);
      7'd18: m = span(col, 6, 7) || span(col, 14, 15) || span(col, 22, 23)
              || span(col, 25, 27) || span(col, 38, 39) || span(col, 45, 46)
              || span(col, 53, 54);
      7'd19: m = span(col, 6, 7) || span(col, 14, 15) || span(col, 22, 23)
              || span(col, 30, 30) || span(col, 38, 39) || span(col, 45, 47)
              || span(col, 53, 54);
      7'd20: m = span(col, 6, 7) || span(col, 14, 15) || span(col, 22, 24)
              || span(col, 29, 30) || span(col, 38, 39) || span(col, 46, 48)
              || span(col, 52, 54);
      7'd21: m = span(col, 7, 7) || span(col, 14, 14) || span(col, 23, 29)
              || span(col, 38, 39) || span(col, 47, 53);
      7'd22: m = span(col, 7, 7) || span(col, 14, 14) || span(col, 25, 28)
              || span(col, 38, 39) || span(col, 48, 52);
      [7'd23:7'd27]: m = span(col, 38, 39); // tail of the y
      [7'd28:7'd29]: m = span(col, 38, 38);
      // rounded button, triangle cut out of rows 43..61
      7'd35, 7'd69: m = span(col, 18, 42);
      7'd36, 7'd68: m = span(col, 11, 50);
      7'd37, 7'd67: m = span(col, 6, 54);
      7'd38, 7'd66: m = span(col, 3, 57);
      7'd39, 7'd65: m = span(col, 2, 58);
      [7'd40:7'd42], [7'd62:7'd64]: m = span(col, 1, 59);
      7'd43, 7'd61: m = span(col, 0, 33) || span(col, 38, 60);
      7'd44, 7'd60: m = span(col, 0, 31) || span(col, 39, 60);
      7'd45, 7'd59: m = span(col, 0, 29) || span(col, 39, 60);
      7'd46, 7'd58: m = span(col, 0, 27) || span(col, 39, 60);
      7'd47, 7'd57: m = span(col, 0, 25) || span(col, 39, 60);
      7'd48, 7'd56: m = span(col, 0, 23) || span(col, 39, 60);
      7'd49, 7'd55: m = span(col, 0, 21) || span(col, 39, 60);
      7'd50, 7'd54: m = span(col, 0, 20) || span(col, 39, 60);
      [7'd51:7'd53]: m = span(col, 0, 19) || span(col, 39, 60); // triangle tip
      default: m = 1'b0;
    endcase
    return m;
  endfunction

  assign dx    = {1'b0, pos.coord.x} - {1'b0, origin.x};
  assign dy    = {1'b0, pos.coord.y} - {1'b0, origin.y};
  assign inBox = !dx[9] && !dy[8] && (dx[8:0] < `T07_SPRITE_W) && (dy[7:0] < `T07_SPRITE_H);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      hitValid <= 1'b0;
    end else if (advance) begin
      hitValid <= posValid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      hitPos <= pos;
      hit    <= inBox && bitmapHit(dy[6:0], dx[5:0]);
    end
  end

endmodule

// ==== verilog/t07_menuRegs.sv ====
`timescale 1ns/1ps
`include "t07_consts.svh"

module t07_menuRegs (
  input  logic              clk,
  input  logic              nrst,
  // write address and data
  input  logic [3:0]        awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  // write response
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  // read
  input  logic [3:0]        araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  output t07_pkg::menuCfg_t cfg
);

  logic              wrAccept;
  logic              rdAccept;
  t07_pkg::regWord_u wrCur;  // current contents at awaddr
  t07_pkg::regWord_u wrWord; // contents after byte strobes

  function automatic logic addrKnown(input logic [3:0] addr);
    return addr inside {`T07_REG_CTRL, `T07_REG_ORIGIN, `T07_REG_COLOR};
  endfunction

  // register contents as seen by the host, zero for unmapped offsets
  function automatic t07_pkg::regWord_u regValue(input logic [3:0] addr);
    t07_pkg::regWord_u word;
    word = '0;
    case (addr)
      `T07_REG_CTRL: word[0] = cfg.enable;
      `T07_REG_ORIGIN: begin
        word.originView.x = cfg.origin.x;
        word.originView.y = cfg.origin.y;
      end
      `T07_REG_COLOR: begin
        word.colorView.fg = cfg.fg;
        word.colorView.bg = cfg.bg;
      end
      default: word = '0;
    endcase
    return word;
  endfunction

  // address and data must arrive together, one write outstanding at most
  assign wrAccept = awvalid && wvalid && !bvalid;
  assign awready  = wrAccept;
  assign wready   = wrAccept;

  always_comb begin
    wrCur = regValue(awaddr);
    for (int i = 0; i < 4; i++) begin
      wrWord[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : wrCur[8*i +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      cfg <= '{enable: 1'b1,
               origin: '{x: `T07_DEF_ORIGIN_X, y: `T07_DEF_ORIGIN_Y},
               fg: `T07_DEF_FG,
               bg: `T07_DEF_BG};
      bvalid <= 1'b0;
      bresp  <= `T07_RESP_OKAY;
    end else if (wrAccept) begin
      bvalid <= 1'b1;
      bresp  <= addrKnown(awaddr) ? `T07_RESP_OKAY : `T07_RESP_SLVERR;
      case (awaddr)
        `T07_REG_CTRL: cfg.enable <= wrWord[0];
        `T07_REG_ORIGIN: begin
          cfg.origin.x <= wrWord.originView.x;
          cfg.origin.y <= wrWord.originView.y;
        end
        `T07_REG_COLOR: begin
          cfg.fg <= wrWord.colorView.fg;
          cfg.bg <= wrWord.colorView.bg;
        end
        default: ; // unmapped, only the error response
      endcase
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  assign arready  = !rvalid;
  assign rdAccept = arvalid && arready;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      rvalid <= 1'b0;
      rresp  <= `T07_RESP_OKAY;
    end else if (rdAccept) begin
      rvalid <= 1'b1;
      rresp  <= addrKnown(araddr) ? `T07_RESP_OKAY : `T07_RESP_SLVERR;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rdAccept) begin
      rdata <= regValue(araddr);
    end
  end

endmodule

// ==== verilog/t07_menuScreen.sv ====
`timescale 1ns/1ps

module t07_menuScreen (
  input  logic            clk,
  input  logic            nrst,
  input  logic [3:0]      awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  logic [31:0]     wdata,
  input  logic [3:0]      wstrb,
  input  logic            wvalid,
  output logic            wready,
  output logic [1:0]      bresp,
  output logic            bvalid,
  input  logic            bready,
  input  logic [3:0]      araddr,
  input  logic            arvalid,
  output logic            arready,
  output logic [31:0]     rdata,
  output logic [1:0]      rresp,
  output logic            rvalid,
  input  logic            rready,
  output t07_pkg::pixel_t pixel,
  output logic            pixelValid,
  input  logic            pixelReady
);

  t07_pkg::menuCfg_t cfg;
  t07_pkg::scanPos_t scanPos;
  t07_pkg::scanPos_t hitPos;
  logic              scanValid;
  logic              hit;
  logic              hitValid;
  logic              advance;

  // one enable for the whole pixel pipeline, stalls only on a full output
  assign advance = !pixelValid || pixelReady;

  t07_menuRegs u_menuRegs (
    .clk(clk), .nrst(nrst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .cfg(cfg)
  );

  t07_pixelScan u_pixelScan (
    .clk(clk), .nrst(nrst), .advance(advance),
    .pos(scanPos), .posValid(scanValid)
  );

  t07_generatePlayButton u_generatePlayButton (
    .clk(clk), .nrst(nrst), .advance(advance),
    .pos(scanPos), .posValid(scanValid), .origin(cfg.origin),
    .hitPos(hitPos), .hit(hit), .hitValid(hitValid)
  );

  t07_pixelColor u_pixelColor (
    .clk(clk), .nrst(nrst), .advance(advance),
    .hit(hit), .hitPos(hitPos), .hitValid(hitValid), .cfg(cfg),
    .pixel(pixel), .pixelValid(pixelValid)
  );

endmodule

// ==== verilog/t07_pixelColor.sv ====
`timescale 1ns/1ps

module t07_pixelColor (
  input  logic              clk,
  input  logic              nrst,
  input  logic              advance,
  input  logic              hit,
  input  t07_pkg::scanPos_t hitPos,
  input  logic              hitValid,
  input  t07_pkg::menuCfg_t cfg,
  output t07_pkg::pixel_t   pixel,
  output logic              pixelValid
);

  t07_pkg::rgb_t color;

  // sprite shows only while enabled, background everywhere else
  assign color = (hit && cfg.enable) ? cfg.fg : cfg.bg;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      pixelValid <= 1'b0;
    end else if (advance) begin
      pixelValid <= hitValid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      pixel <= '{rgb: color,
                 frameStart: hitPos.frameStart,
                 lineEnd: hitPos.lineEnd};
    end
  end

endmodule

// ==== verilog/t07_pixelScan.sv ====
`timescale 1ns/1ps
`include "t07_consts.svh"

module t07_pixelScan (
  input  logic              clk,
  input  logic              nrst,
  input  logic              advance,
  output t07_pkg::scanPos_t pos,
  output logic              posValid
);

  t07_pkg::screenPos_t cur;
  logic                lastX;
  logic                lastY;

  assign lastX = cur.x == 9'(`T07_SCREEN_W - 1);
  assign lastY = cur.y == 8'(`T07_SCREEN_H - 1);

  // the first advance only fills the stage, later ones step the counter
  always_ff @(posedge clk) begin
    if (!nrst) begin
      cur      <= '0;
      posValid <= 1'b0;
    end else begin
      posValid <= 1'b1;
      if (advance && posValid) begin
        if (lastX) begin
          cur.x <= '0;
          cur.y <= lastY ? '0 : cur.y + 8'd1; // wrap at frame end
        end else begin
          cur.x <= cur.x + 9'd1;
        end
      end
    end
  end

  assign pos = '{coord: cur,
                 frameStart: (cur.x == '0) && (cur.y == '0),
                 lineEnd: lastX};

endmodule

// ==== verilog/t07_pkg.sv ====
`include "t07_consts.svh"

package t07_pkg;

  typedef struct packed {
    logic [$clog2(`T07_SCREEN_W)-1:0] x;
    logic [$clog2(`T07_SCREEN_H)-1:0] y;
  } screenPos_t;

  typedef struct packed {
    screenPos_t coord;
    logic       frameStart; // set on 0,0
    logic       lineEnd;    // set on the last column
  } scanPos_t;

  typedef logic [11:0] rgb_t; // 4 bits each of r, g, b

  typedef struct packed {
    rgb_t rgb;
    logic frameStart;
    logic lineEnd;
  } pixel_t;

  // host write word, read as an origin or as a color pair
  typedef union packed {
    struct packed {
      logic [14:0] pad;
      logic [7:0]  y;
      logic [8:0]  x;
    } originView;
    struct packed {
      logic [7:0] pad;
      rgb_t       bg;
      rgb_t       fg;
    } colorView;
  } regWord_u;

  typedef struct packed {
    logic       enable;
    screenPos_t origin;
    rgb_t       fg;
    rgb_t       bg;
  } menuCfg_t;

endpackage
